//--- verilog/dft_params.svh
// Width, frame length and twiddle precision macros for the DFT engine.
`ifndef DFT_PARAMS_SVH
`define DFT_PARAMS_SVH

// Real and imaginary width of one input point.
`define DFT_IN_W 18

// Real and imaginary width of one output bin.
`define DFT_OUT_W 30

`define DFT_PTS_W 12 // Width of the dftpts field on both sides.

// Largest frame the single radix kernel handles.
`define DFT_MAX_PTS 5

// Twiddle constants are Q14, so 1.0 is 16384.
`define DFT_TW_FRAC 14

`endif

//--- verilog/dft_pkg.sv
// Sample, result and frame configuration types for the DFT engine.
`include "dft_params.svh"

package dft_pkg;

	// One complex input point as it arrives on the sink.
	typedef struct packed
	{
		logic signed [`DFT_IN_W-1:0] re;
		logic signed [`DFT_IN_W-1:0] im;
	} dft_sample_t;

	// One complex output bin, full growth after the Q14 shift.
	typedef struct packed
	{
		logic signed [`DFT_OUT_W-1:0] re;
		logic signed [`DFT_OUT_W-1:0] im;
	} dft_result_t;

	// Settings captured on the sop beat and held for the whole frame.
	typedef struct packed
	{
		logic [`DFT_PTS_W-1:0] pts; // Frame length, 2 to 5.
		logic inverse; // Conjugate twiddles when set.
	} dft_cfg_t;

endpackage

//--- verilog/dft_frame_in.sv
// Sink side of the DFT engine: frame capture, sample store and per-frame settings.
`timescale 1ns/1ns
`include "dft_params.svh"

module dft_frame_in
(
	input logic clk,
	input logic rst,
	input logic sink_valid,
	input logic sink_sop,
	input logic sink_eop,
	input logic inverse,
	input logic [`DFT_IN_W-1:0] sink_real,
	input logic [`DFT_IN_W-1:0] sink_imag,
	input logic [`DFT_PTS_W-1:0] dftpts_in,
	output logic sink_ready,
	input logic busy,
	input logic [2:0] samp_idx,
	output dft_pkg::dft_sample_t rd_sample,
	output dft_pkg::dft_cfg_t cfg,
	output logic frame_done
);

	dft_pkg::dft_sample_t mem [0:`DFT_MAX_PTS-1];
	logic [2:0] wr_cnt;
	logic [2:0] wr_idx;
	logic accept;
	logic [`DFT_PTS_W-1:0] beat_num;
	logic [`DFT_PTS_W-1:0] eff_pts;

	assign sink_ready = !busy; // Only one frame is in flight at a time.
	assign accept = sink_valid && sink_ready;
	assign wr_idx = sink_sop ? 3'd0 : wr_cnt;
	assign frame_done = accept && sink_eop;

	// Write counter, restarted by every sop beat.
	always_ff @(posedge clk)
	begin
		if (rst)
			wr_cnt <= 3'd0;
		else if (accept)
			wr_cnt <= wr_idx + 3'd1;
	end

	always_ff @(posedge clk)
	begin
		if (accept && (wr_idx < 3'(`DFT_MAX_PTS)))
		begin
			mem[wr_idx].re <= sink_real;
			mem[wr_idx].im <= sink_imag;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			cfg <= '0;
		else if (accept && sink_sop)
		begin
			cfg.pts <= dftpts_in;
			cfg.inverse <= inverse; // Only sampled on the first beat.
		end
	end

	assign rd_sample = mem[samp_idx]; // Combinational read for the kernel.

	assign beat_num = `DFT_PTS_W'(wr_idx) + `DFT_PTS_W'(1);
	assign eff_pts = sink_sop ? dftpts_in : cfg.pts;

	// The eop beat must be the frame's last point.
	a_eop_at_pts: assert property (@(posedge clk) disable iff (rst)
		(accept && sink_eop) |-> (beat_num == eff_pts));

	a_sop_pts_range: assert property (@(posedge clk) disable iff (rst)
		(accept && sink_sop) |-> (dftpts_in >= `DFT_PTS_W'(2) &&
		dftpts_in <= `DFT_PTS_W'(`DFT_MAX_PTS)));

endmodule

//--- verilog/dft_ctrl_fsm.sv
// Collect, compute and drain sequencer with bin and sample counters.
`timescale 1ns/1ns

module dft_ctrl_fsm
(
	input logic clk,
	input logic rst,
	input logic frame_done,
	input logic drain_done,
	input dft_pkg::dft_cfg_t cfg,
	output logic busy,
	output logic mac_start,
	output logic mac_last,
	output logic drain_start,
	output logic [2:0] bin_idx,
	output logic [2:0] samp_idx
);

	typedef enum logic [1:0] {IDLE, COMPUTE, DRAIN} state_t;

	state_t state;
	logic [2:0] last_idx;

	assign last_idx = cfg.pts[2:0] - 3'd1;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			bin_idx <= 3'd0;
			samp_idx <= 3'd0;
			drain_start <= 1'b0;
		end
		else
		begin
			drain_start <= 1'b0;
			case (state)
				IDLE:
				begin
					if (frame_done)
					begin
						state <= COMPUTE;
						bin_idx <= 3'd0;
						samp_idx <= 3'd0;
					end
				end
				COMPUTE:
				begin
					if (samp_idx == last_idx)
					begin
						samp_idx <= 3'd0;
						if (bin_idx == last_idx)
						begin
							state <= DRAIN;
							drain_start <= 1'b1; // Last bin leaves the core next cycle.
						end
						else
							bin_idx <= bin_idx + 3'd1;
					end
					else
						samp_idx <= samp_idx + 3'd1;
				end
				DRAIN:
				begin
					if (drain_done)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign busy = (state != IDLE);
	assign mac_start = (state == COMPUTE) && (samp_idx == 3'd0);
	assign mac_last = (state == COMPUTE) && (samp_idx == last_idx);

	// The sink reopens only on an eop transfer reported while the FSM drains.
	a_done_in_drain: assert property (@(posedge clk) disable iff (rst)
		drain_done |-> (state == DRAIN));

endmodule

//--- verilog/dft_rdx2345_core.sv
// Radix 2/3/4/5 kernel: complex multiply-accumulate against a Q14 twiddle ROM.
`timescale 1ns/1ns
`include "dft_params.svh"

module dft_rdx2345_core
(
	input logic clk,
	input logic rst,
	input dft_pkg::dft_cfg_t cfg,
	input logic mac_start,
	input logic mac_last,
	input logic [2:0] bin_idx,
	input logic [2:0] samp_idx,
	input dft_pkg::dft_sample_t rd_sample,
	output logic bin_valid,
	output logic [2:0] bin_out_idx,
	output dft_pkg::dft_result_t bin
);

	localparam int ACC_W = 40;
	localparam int TW_W = `DFT_TW_FRAC + 2;

	logic [2:0] n_pts;
	logic [2:0] m_reg;
	logic [2:0] m_cur;
	logic [3:0] m_sum;
	logic signed [TW_W-1:0] tw_cos;
	logic signed [TW_W-1:0] tw_sin;
	logic signed [TW_W-1:0] tw_im;
	logic signed [ACC_W-1:0] xr;
	logic signed [ACC_W-1:0] xi;
	logic signed [ACC_W-1:0] tc;
	logic signed [ACC_W-1:0] ts;
	logic signed [ACC_W-1:0] prod_re;
	logic signed [ACC_W-1:0] prod_im;
	logic signed [ACC_W-1:0] acc_re;
	logic signed [ACC_W-1:0] acc_im;
	logic signed [ACC_W-1:0] sum_re;
	logic signed [ACC_W-1:0] sum_im;
	logic signed [ACC_W-1:0] shr_re;
	logic signed [ACC_W-1:0] shr_im;
	logic in_bin;

	assign n_pts = cfg.pts[2:0];

	// Twiddle index k*n mod N, stepped by k each sample instead of multiplied.
	assign m_cur = (samp_idx == 3'd0) ? 3'd0 : m_reg;
	assign m_sum = {1'b0, m_cur} + {1'b0, bin_idx};

	always_ff @(posedge clk)
	begin
		if (rst)
			m_reg <= 3'd0;
		else if (m_sum >= {1'b0, n_pts})
			m_reg <= 3'(m_sum - {1'b0, n_pts});
		else
			m_reg <= m_sum[2:0];
	end

	// Q14 cos of 2*pi*m/N.
	always_comb
	begin
		case ({n_pts, m_cur})
			{3'd2, 3'd1}: tw_cos = -TW_W'(16384);
			{3'd3, 3'd1}: tw_cos = -TW_W'(8192);
			{3'd3, 3'd2}: tw_cos = -TW_W'(8192);
			{3'd4, 3'd1}: tw_cos = '0;
			{3'd4, 3'd2}: tw_cos = -TW_W'(16384);
			{3'd4, 3'd3}: tw_cos = '0;
			{3'd5, 3'd1}: tw_cos = TW_W'(5063);
			{3'd5, 3'd2}: tw_cos = -TW_W'(13255);
			{3'd5, 3'd3}: tw_cos = -TW_W'(13255);
			{3'd5, 3'd4}: tw_cos = TW_W'(5063);
			default: tw_cos = TW_W'(16384);
		endcase
	end

	// Q14 sin of 2*pi*m/N.
	always_comb
	begin
		case ({n_pts, m_cur})
			{3'd3, 3'd1}: tw_sin = TW_W'(14189);
			{3'd3, 3'd2}: tw_sin = -TW_W'(14189);
			{3'd4, 3'd1}: tw_sin = TW_W'(16384);
			{3'd4, 3'd3}: tw_sin = -TW_W'(16384);
			{3'd5, 3'd1}: tw_sin = TW_W'(15582);
			{3'd5, 3'd2}: tw_sin = TW_W'(9630);
			{3'd5, 3'd3}: tw_sin = -TW_W'(9630);
			{3'd5, 3'd4}: tw_sin = -TW_W'(15582);
			default: tw_sin = '0;
		endcase
	end

	assign tw_im = cfg.inverse ? tw_sin : -tw_sin; // Forward transform uses exp(-j...).

	assign xr = ACC_W'(rd_sample.re);
	assign xi = ACC_W'(rd_sample.im);
	assign tc = ACC_W'(tw_cos);
	assign ts = ACC_W'(tw_im);

	assign prod_re = xr * tc - xi * ts;
	assign prod_im = xr * ts + xi * tc;

	assign sum_re = mac_start ? prod_re : acc_re + prod_re;
	assign sum_im = mac_start ? prod_im : acc_im + prod_im;

	always_ff @(posedge clk)
	begin
		acc_re <= sum_re;
		acc_im <= sum_im;
	end

	// Arithmetic shift floors toward negative infinity.
	assign shr_re = sum_re >>> `DFT_TW_FRAC;
	assign shr_im = sum_im >>> `DFT_TW_FRAC;

	always_ff @(posedge clk)
	begin
		if (rst)
			bin_valid <= 1'b0;
		else
			bin_valid <= mac_last;
	end

	always_ff @(posedge clk)
	begin
		if (mac_last)
		begin
			bin.re <= shr_re[`DFT_OUT_W-1:0];
			bin.im <= shr_im[`DFT_OUT_W-1:0];
			bin_out_idx <= bin_idx;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			in_bin <= 1'b0;
		else if (mac_last)
			in_bin <= 1'b0;
		else if (mac_start)
			in_bin <= 1'b1;
	end

	// The controller must open every bin before closing it.
	a_last_after_start: assert property (@(posedge clk) disable iff (rst)
		mac_last |-> (in_bin || mac_start));

endmodule

//--- verilog/dft_frame_out.sv
// Source side of the DFT engine: bin buffer and sop/eop framing with back-pressure.
`timescale 1ns/1ns
`include "dft_params.svh"

module dft_frame_out
(
	input logic clk,
	input logic rst,
	input logic bin_valid,
	input logic [2:0] bin_out_idx,
	input dft_pkg::dft_result_t bin,
	input logic drain_start,
	input dft_pkg::dft_cfg_t cfg,
	input logic source_ready,
	output logic source_valid,
	output logic source_sop,
	output logic source_eop,
	output logic [`DFT_OUT_W-1:0] source_real,
	output logic [`DFT_OUT_W-1:0] source_imag,
	output logic [`DFT_PTS_W-1:0] dftpts_out,
	output logic drain_done
);

	dft_pkg::dft_result_t bin_buf [0:`DFT_MAX_PTS-1];
	logic [2:0] beat_idx;
	logic [2:0] next_idx;
	logic [2:0] last_idx;
	logic advance;

	always_ff @(posedge clk)
	begin
		if (bin_valid)
			bin_buf[bin_out_idx] <= bin;
	end

	assign last_idx = cfg.pts[2:0] - 3'd1;
	assign next_idx = beat_idx + 3'd1;
	assign advance = source_valid && source_ready;
	assign drain_done = advance && source_eop;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			source_valid <= 1'b0;
			source_sop <= 1'b0;
			source_eop <= 1'b0;
			beat_idx <= 3'd0;
		end
		else if (drain_start)
		begin
			source_valid <= 1'b1;
			source_sop <= 1'b1;
			source_eop <= 1'b0; // Frames are at least two points long.
			beat_idx <= 3'd0;
		end
		else if (advance)
		begin
			source_sop <= 1'b0;
			if (source_eop)
			begin
				source_valid <= 1'b0;
				source_eop <= 1'b0;
			end
			else
			begin
				beat_idx <= next_idx;
				source_eop <= (next_idx == last_idx);
			end
		end
	end

	// Payload only moves on a load or a transfer, so a stalled beat holds.
	always_ff @(posedge clk)
	begin
		if (drain_start)
		begin
			source_real <= bin_buf[0].re;
			source_imag <= bin_buf[0].im;
			dftpts_out <= cfg.pts;
		end
		else if (advance && !source_eop)
		begin
			source_real <= bin_buf[next_idx].re;
			source_imag <= bin_buf[next_idx].im;
		end
	end

	a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
		(source_valid && !source_ready) |=> (source_valid && $stable(source_real) &&
		$stable(source_imag) && $stable(source_sop) && $stable(source_eop) &&
		$stable(dftpts_out)));

endmodule

//--- verilog/dft_top.sv
// Top level of the streaming mixed-radix DFT engine.
`timescale 1ns/1ns
`include "dft_params.svh"

module dft_top
(
	input logic clk,
	input logic rst,

	input logic sink_valid,
	output logic sink_ready,
	input logic sink_sop,
	input logic sink_eop,
	input logic [`DFT_IN_W-1:0] sink_real,
	input logic [`DFT_IN_W-1:0] sink_imag,
	input logic [`DFT_PTS_W-1:0] dftpts_in,
	input logic inverse,

	output logic source_valid,
	input logic source_ready,
	output logic source_sop,
	output logic source_eop,
	output logic [`DFT_OUT_W-1:0] source_real,
	output logic [`DFT_OUT_W-1:0] source_imag,
	output logic [`DFT_PTS_W-1:0] dftpts_out
);

	dft_pkg::dft_cfg_t cfg;
	dft_pkg::dft_sample_t rd_sample;
	dft_pkg::dft_result_t bin;
	logic frame_done;
	logic busy;
	logic mac_start;
	logic mac_last;
	logic drain_start;
	logic drain_done;
	logic bin_valid;
	logic [2:0] bin_idx;
	logic [2:0] samp_idx;
	logic [2:0] bin_out_idx;

	dft_frame_in frame_in_i
	(
		.clk(clk), .rst(rst),
		.sink_valid(sink_valid), .sink_sop(sink_sop), .sink_eop(sink_eop),
		.inverse(inverse), .sink_real(sink_real), .sink_imag(sink_imag),
		.dftpts_in(dftpts_in), .sink_ready(sink_ready), .busy(busy),
		.samp_idx(samp_idx), .rd_sample(rd_sample), .cfg(cfg), .frame_done(frame_done)
	);

	dft_ctrl_fsm ctrl_fsm_i
	(
		.clk(clk), .rst(rst),
		.frame_done(frame_done), .drain_done(drain_done), .cfg(cfg),
		.busy(busy), .mac_start(mac_start), .mac_last(mac_last),
		.drain_start(drain_start), .bin_idx(bin_idx), .samp_idx(samp_idx)
	);

	dft_rdx2345_core rdx2345_core_i
	(
		.clk(clk), .rst(rst),
		.cfg(cfg), .mac_start(mac_start), .mac_last(mac_last),
		.bin_idx(bin_idx), .samp_idx(samp_idx), .rd_sample(rd_sample),
		.bin_valid(bin_valid), .bin_out_idx(bin_out_idx), .bin(bin)
	);

	dft_frame_out frame_out_i
	(
		.clk(clk), .rst(rst),
		.bin_valid(bin_valid), .bin_out_idx(bin_out_idx), .bin(bin),
		.drain_start(drain_start), .cfg(cfg), .source_ready(source_ready),
		.source_valid(source_valid), .source_sop(source_sop), .source_eop(source_eop),
		.source_real(source_real), .source_imag(source_imag),
		.dftpts_out(dftpts_out), .drain_done(drain_done)
	);

endmodule

//--- test/dft_clk_gen.sv
// Free-running testbench clock with a 20 ns period.
`timescale 1ns/1ns

module dft_clk_gen
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk; // Half of the 20 ns period.
	end

endmodule

//--- test/dft_tb.sv
// Testbench for the DFT engine: stimulus, reference model, output checks and timeout.
`timescale 1ns/1ns
`include "dft_params.svh"

module dft_tb;

	localparam logic [31:0] SEED = 32'h5f4778c8;
	localparam int NUM_FRAMES = 40;
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * (5 * 5 + 2 + 5 * 4) + 200;
	localparam int KIND_IMPULSE = 0;
	localparam int KIND_DC = 1;
	localparam int KIND_RANDOM = 2;
	localparam real PI = 3.14159265358979323846;

	// What the checker needs to know about one expected output beat.
	typedef struct packed
	{
		logic first;
		logic last;
		logic exact; // Bin must match with no twiddle tolerance.
		logic [2:0] k;
		logic [`DFT_PTS_W-1:0] pts;
	} beat_tag_t;

	logic clk;
	logic rst;
	logic sink_valid;
	logic sink_ready;
	logic sink_sop;
	logic sink_eop;
	logic [`DFT_IN_W-1:0] sink_real;
	logic [`DFT_IN_W-1:0] sink_imag;
	logic [`DFT_PTS_W-1:0] dftpts_in;
	logic inverse;
	logic source_valid;
	logic source_ready;
	logic source_sop;
	logic source_eop;
	logic [`DFT_OUT_W-1:0] source_real;
	logic [`DFT_OUT_W-1:0] source_imag;
	logic [`DFT_PTS_W-1:0] dftpts_out;

	logic [31:0] data_seed;
	logic [31:0] ready_seed;
	beat_tag_t tag_q [$];
	real exp_re_q [$];
	real exp_im_q [$];
	int frames_pending;
	int cycle_cnt = 0;
	int value_errors = 0;
	int frame_errors = 0;
	int hold_errors = 0;
	int busy_errors = 0;
	int reopen_errors = 0;
	int frame_num;
	int frame_len;
	bit frame_inv;

	dft_clk_gen clk_gen_i
	(
		.clk(clk)
	);

	dft_top dft_top_i
	(
		.clk(clk), .rst(rst),
		.sink_valid(sink_valid), .sink_ready(sink_ready), .sink_sop(sink_sop),
		.sink_eop(sink_eop), .sink_real(sink_real), .sink_imag(sink_imag),
		.dftpts_in(dftpts_in), .inverse(inverse),
		.source_valid(source_valid), .source_ready(source_ready),
		.source_sop(source_sop), .source_eop(source_eop),
		.source_real(source_real), .source_imag(source_imag), .dftpts_out(dftpts_out)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic bit near(input int got, input real want, input int tol);
		real d;
		d = real'(got) - want;
		return (d <= real'(tol)) && (d >= -real'(tol));
	endfunction

	// Builds one frame, queues its expected bins, then streams it into the sink.
	task automatic send_frame(input int n, input bit inv, input int kind);
		int xr [0:4];
		int xi [0:4];
		int i;
		int k;
		int m;
		real th;
		real er;
		real ei;
		real sg;
		beat_tag_t tag;
		for (i = 0; i < n; i++)
		begin
			if (kind == KIND_RANDOM || i == 0)
			begin
				data_seed = lcg_step(data_seed);
				xr[i] = int'($signed(data_seed[31:18]));
				data_seed = lcg_step(data_seed);
				xi[i] = int'($signed(data_seed[31:18]));
			end
			else if (kind == KIND_DC)
			begin
				xr[i] = xr[0];
				xi[i] = xi[0];
			end
			else
			begin
				xr[i] = 0;
				xi[i] = 0;
			end
		end
		sg = inv ? 1.0 : -1.0; // Forward transform uses exp(-j 2 pi m / N).
		for (k = 0; k < n; k++)
		begin
			er = 0.0;
			ei = 0.0;
			for (i = 0; i < n; i++)
			begin
				m = (k * i) % n;
				th = 2.0 * PI * real'(m) / real'(n);
				er = er + real'(xr[i]) * $cos(th) - sg * real'(xi[i]) * $sin(th);
				ei = ei + sg * real'(xr[i]) * $sin(th) + real'(xi[i]) * $cos(th);
			end
			tag.first = (k == 0);
			tag.last = (k == n - 1);
			tag.exact = (kind == KIND_IMPULSE) || (kind == KIND_DC && k == 0);
			tag.k = 3'(k);
			tag.pts = `DFT_PTS_W'(n);
			tag_q.push_back(tag);
			exp_re_q.push_back(er);
			exp_im_q.push_back(ei);
		end
		for (i = 0; i < n; i++)
		begin
			@(negedge clk);
			sink_valid = 1'b1;
			sink_sop = (i == 0);
			sink_eop = (i == n - 1);
			sink_real = `DFT_IN_W'(xr[i]);
			sink_imag = `DFT_IN_W'(xi[i]);
			if (i == 0)
			begin
				dftpts_in = `DFT_PTS_W'(n);
				inverse = inv;
			end
			else
			begin
				// Later beats carry junk settings that the DUT must ignore.
				data_seed = lcg_step(data_seed);
				dftpts_in = `DFT_PTS_W'(2 + int'(data_seed[31:30]));
				inverse = data_seed[29];
			end
			@(posedge clk);
			while (!sink_ready)
				@(posedge clk);
		end
		@(negedge clk);
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
	endtask

	task automatic check_beat();
		beat_tag_t tag;
		real er;
		real ei;
		int dr;
		int di;
		int tol;
		tag = tag_q.pop_front();
		er = exp_re_q.pop_front();
		ei = exp_im_q.pop_front();
		dr = int'($signed(source_real));
		di = int'($signed(source_imag));
		tol = tag.exact ? 0 : int'(tag.pts); // Twiddle rounding costs up to N LSB.
		assert (source_sop == tag.first && source_eop == tag.last)
		else
		begin
			frame_errors++;
			$display("MISMATCH at %0t: bin %0d sop %0b eop %0b, expected sop %0b eop %0b",
				$time, tag.k, source_sop, source_eop, tag.first, tag.last);
		end
		assert (dftpts_out == tag.pts)
		else
		begin
			frame_errors++;
			$display("MISMATCH at %0t: dftpts_out %0d, expected %0d",
				$time, dftpts_out, tag.pts);
		end
		assert (near(dr, er, tol) && near(di, ei, tol))
		else
		begin
			value_errors++;
			$display("MISMATCH at %0t: N=%0d bin %0d got (%0d, %0d), expected (%.2f, %.2f)",
				$time, tag.pts, tag.k, dr, di, er, ei);
		end
	endtask

	// Every transferred output beat is compared with the oldest queued bin.
	always @(posedge clk)
	begin
		if (!rst && source_valid && source_ready)
		begin
			if (tag_q.size() == 0)
			begin
				frame_errors++;
				$display("Output beat at %0t arrived with no bin outstanding.", $time);
			end
			else
				check_beat();
		end
	end

	always @(posedge clk)
	begin
		if (rst)
			frames_pending <= 0;
		else
			frames_pending <= frames_pending
				+ ((sink_valid && sink_ready && sink_eop) ? 1 : 0)
				- ((source_valid && source_ready && source_eop) ? 1 : 0);
	end

	a_hold_stall: assert property (@(posedge clk) disable iff (rst)
		(source_valid && !source_ready) |=> (source_valid && $stable(source_real) &&
		$stable(source_imag) && $stable(source_sop) && $stable(source_eop) &&
		$stable(dftpts_out)))
	else
	begin
		hold_errors++;
		$display("Stalled output beat changed under back-pressure at %0t.", $time);
	end

	// The sink stays closed from the accepted eop until that frame has drained.
	a_sink_closed: assert property (@(posedge clk) disable iff (rst)
		(frames_pending != 0) |-> !sink_ready)
	else
	begin
		busy_errors++;
		$display("Sink accepted data at %0t while a frame was still in flight.", $time);
	end

	a_sink_reopen: assert property (@(posedge clk) disable iff (rst)
		(source_valid && source_ready && source_eop) |=> sink_ready)
	else
	begin
		reopen_errors++;
		$display("Sink did not reopen at %0t after the output eop.", $time);
	end

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	initial
	begin
		while (cycle_cnt < TIMEOUT_CYCLES)
			@(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	// Random back-pressure, about three cycles in four ready.
	initial
	begin
		ready_seed = ~SEED;
		source_ready = 1'b0;
		forever
		begin
			@(negedge clk);
			ready_seed = lcg_step(ready_seed);
			source_ready = (ready_seed[31:30] != 2'b00);
		end
	end

	initial
	begin
		data_seed = SEED;
		rst = 1'b1;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		sink_real = '0;
		sink_imag = '0;
		dftpts_in = '0;
		inverse = 1'b0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		for (frame_num = 0; frame_num < NUM_FRAMES; frame_num++)
		begin
			if (frame_num < 4)
				send_frame(frame_num + 2, frame_num[0], KIND_IMPULSE);
			else if (frame_num < 8)
				send_frame(frame_num - 2, !frame_num[0], KIND_DC);
			else
			begin
				data_seed = lcg_step(data_seed);
				frame_len = 2 + int'(data_seed[31:30]);
				frame_inv = data_seed[29];
				send_frame(frame_len, frame_inv, KIND_RANDOM);
			end
		end
		while (tag_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk); // Lets the last reopen check complete.
		@(negedge clk);
		$display("Error counts: value %0d, framing %0d, hold %0d, busy %0d, reopen %0d",
			value_errors, frame_errors, hold_errors, busy_errors, reopen_errors);
		if (value_errors + frame_errors + hold_errors + busy_errors + reopen_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- build.f
+incdir+verilog
verilog/dft_pkg.sv
verilog/dft_frame_in.sv
verilog/dft_ctrl_fsm.sv
verilog/dft_rdx2345_core.sv
verilog/dft_frame_out.sv
verilog/dft_top.sv
test/dft_clk_gen.sv
test/dft_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the DFT testbench with Verilator, runs it into a log and checks the result.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module dft_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/Vdft_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Finished with no errors" "$LOG"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1
